// ==== filelist.f ====
+incdir+source
source/ifu_pkg.sv
source/ifu_if.sv
source/inst_sram.sv
source/inst_fetch.sv
source/inst_queue.sv
source/inst_decode.sv
source/fetch_top.sv
dv/tb_fetch_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found in PATH"
  exit 1
fi

if ! verilator --binary --timing -j 0 -f filelist.f --top-module tb_fetch_top \
    -Mdir obj_dir -o sim_fetch_top; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_fetch_top 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi

echo "Simulation ended without reporting success"
exit 1

// ==== dv/tb_fetch_top.sv ====
// Testbench for the fetch front end that loads the SRAM, runs fetch passes and checks decode output
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module tb_fetch_top import ifu_pkg::*; ();

  localparam int WORDS       = `IFU_MEM_WORDS;
  localparam int N_CHECKS    = 6 * WORDS;
  localparam int LOAD_CYCLES = 2 * WORDS * 4 + 64;
  localparam int WDOG_CYCLES = 40 * N_CHECKS + LOAD_CYCLES;

  logic                   i_aclk = 1'b0;
  logic                   i_rst_n;
  logic                   i_fetch_en;
  logic                   i_awvalid;
  logic                   o_awready;
  logic [`IFU_ADDR_W-1:0] i_awaddr;
  logic                   i_wvalid;
  logic                   o_wready;
  logic [`IFU_DATA_W-1:0] i_wdata;
  logic [`IFU_STRB_W-1:0] i_wstrb;
  logic                   o_bvalid;
  logic                   i_bready;
  axi_resp_e              o_bresp;
  logic                   o_dec_valid;
  logic                   i_dec_ready = 1'b1;
  logic [`IFU_ADDR_W-1:0] o_dec_pc;
  logic [31:0]            o_dec_inst;
  inst_class_e            o_dec_class;

  // Expected memory contents and checker state
  logic [`IFU_DATA_W-1:0] shadow [WORDS];
  logic [31:0]            prog_rng = 32'd93066;
  logic [31:0]            ready_rng = 32'd93066;
  logic                   rand_ready = 1'b0;
  logic [`IFU_ADDR_W-1:0] exp_pc;
  logic                   hold_pending;
  logic [`IFU_ADDR_W-1:0] held_pc;
  logic [31:0]            held_inst;
  inst_class_e            held_class;
  int                     n_checked = 0;
  int                     n_bresp = 0;
  int                     n_writes = 0;

  fetch_top u_dut (.*);

  always #10 i_aclk = ~i_aclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference classification by RV64 major opcode
  function automatic inst_class_e class_of(input logic [31:0] inst);
    inst_class_e c;
    case (inst[6:0])
      7'h37:   c = IC_LUI;
      7'h17:   c = IC_AUIPC;
      7'h6f:   c = IC_JAL;
      7'h67:   c = IC_JALR;
      7'h63:   c = IC_BRANCH;
      7'h03:   c = IC_LOAD;
      7'h23:   c = IC_STORE;
      7'h13:   c = IC_OP_IMM;
      7'h33:   c = IC_OP;
      7'h1b:   c = IC_OP_IMM_32;
      7'h3b:   c = IC_OP_32;
      7'h73:   c = IC_SYSTEM;
      7'h0f:   c = IC_MISC_MEM;
      default: c = IC_ILLEGAL;
    endcase
    return c;
  endfunction

  // One opcode per class and a last one outside the major opcode map
  function automatic logic [6:0] opcode_for(input int k);
    logic [6:0] tbl [14];
    tbl = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23,
            7'h13, 7'h33, 7'h1b, 7'h3b, 7'h73, 7'h0f, 7'h7f};
    return tbl[k % 14];
  endfunction

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("t=%0t %s", $time, what);
    abort_run();
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  task automatic check_class(input string name, input inst_class_e exp, input inst_class_e got);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s expected %s got %s", $time, name, exp.name(), got.name());
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e got);
    if (got !== exp) begin
      $display("[ERROR] t=%0t %s expected %s got %s", $time, name, exp.name(), got.name());
      abort_run();
    end
  endtask

  // One AXI-lite write with address and data offered together
  task automatic write_word(input int w, input logic [63:0] data, input logic [7:0] strb);
    int waited;
    @(negedge i_aclk);
    i_awvalid = 1'b1;
    i_wvalid  = 1'b1;
    i_awaddr  = w * 8;
    i_wdata   = data;
    i_wstrb   = strb;
    waited    = 0;
    do begin
      @(posedge i_aclk);
      waited++;
      if (waited > 10) begin
        report_problem($sformatf("write handshake for word %0d never completed", w));
      end
    end while (!(o_awready && o_wready));
    @(negedge i_aclk);
    i_awvalid = 1'b0;
    i_wvalid  = 1'b0;
    n_writes++;
    if (n_bresp != n_writes) begin
      report_problem($sformatf("saw %0d write responses after %0d writes", n_bresp, n_writes));
    end
  endtask

  always @(posedge i_aclk) begin
    if (i_rst_n && o_bvalid && i_bready) begin
      n_bresp++;
      check_resp("o_bresp", RESP_OKAY, o_bresp);
    end
  end

  always @(negedge i_aclk) begin
    if (rand_ready) begin
      ready_rng   = xorshift32(ready_rng);
      i_dec_ready = ready_rng[7];
    end else begin
      i_dec_ready = 1'b1;
    end
  end

  // Compare each decode handshake and check the output holds under back-pressure
  always @(posedge i_aclk) begin : compare_proc
    logic [63:0] word;
    logic [31:0] exp_inst;
    int          idx;
    if (!i_rst_n) begin
      exp_pc       = `IFU_RESET_PC;
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) begin
        if (!o_dec_valid) begin
          report_problem("o_dec_valid dropped while i_dec_ready was low");
        end
        check_word("o_dec_pc (held)", held_pc, o_dec_pc);
        check_word("o_dec_inst (held)", held_inst, o_dec_inst);
        check_class("o_dec_class (held)", held_class, o_dec_class);
      end
      if (o_dec_valid && i_dec_ready) begin
        idx      = int'((exp_pc >> 3) % WORDS);
        word     = shadow[idx];
        exp_inst = exp_pc[2] ? word[63:32] : word[31:0];
        check_word("o_dec_pc", exp_pc, o_dec_pc);
        check_word("o_dec_inst", exp_inst, o_dec_inst);
        check_class("o_dec_class", class_of(exp_inst), o_dec_class);
        exp_pc = exp_pc + 32'd4;
        n_checked++;
      end
      hold_pending = o_dec_valid && !i_dec_ready;
      held_pc      = o_dec_pc;
      held_inst    = o_dec_inst;
      held_class   = o_dec_class;
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge i_aclk);
    report_problem($sformatf("watchdog expired after %0d cycles", WDOG_CYCLES));
  end

  initial begin
    int          target;
    int          sel;
    logic [31:0] half;
    logic [63:0] data;
    logic [7:0]  strb;
    i_rst_n    = 1'b0;
    i_fetch_en = 1'b0;
    i_awvalid  = 1'b0;
    i_awaddr   = '0;
    i_wvalid   = 1'b0;
    i_wdata    = '0;
    i_wstrb    = '0;
    i_bready   = 1'b1;
    repeat (10) @(negedge i_aclk);
    i_rst_n = 1'b1;

    // Idle design must keep every valid and ready low
    repeat (20) begin
      @(posedge i_aclk);
      if (o_dec_valid || o_awready || o_wready || o_bvalid) begin
        report_problem("an output went high while fetch was off and no write was offered");
      end
    end

    // Program with every class in the first 14 instructions
    for (int k = 0; k < 2 * WORDS; k++) begin
      prog_rng = xorshift32(prog_rng);
      sel      = (k < 14) ? k : int'(prog_rng[31:24] % 14);
      prog_rng = xorshift32(prog_rng);
      half     = {prog_rng[31:7], opcode_for(sel)};
      if (k[0]) begin
        shadow[k / 2][63:32] = half;
      end else begin
        shadow[k / 2][31:0] = half;
      end
    end
    for (int w = 0; w < WORDS; w++) begin
      write_word(w, shadow[w], '1);
    end

    // Two full passes where the second reads through the address wrap
    target = n_checked + 4 * WORDS;
    @(negedge i_aclk);
    i_fetch_en = 1'b1;
    wait (n_checked >= target);
    @(negedge i_aclk);
    i_fetch_en = 1'b0;
    i_rst_n    = 1'b0;
    repeat (10) @(negedge i_aclk);
    i_rst_n = 1'b1;

    // Partial writes with random strobes
    for (int w = 0; w < WORDS; w++) begin
      prog_rng   = xorshift32(prog_rng);
      data[31:0] = prog_rng;
      prog_rng   = xorshift32(prog_rng);
      data[63:32] = prog_rng;
      prog_rng   = xorshift32(prog_rng);
      strb       = prog_rng[15:8];
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          shadow[w][b*8 +: 8] = data[b*8 +: 8];
        end
      end
      write_word(w, data, strb);
    end

    // Refetch with random back-pressure on the decode output
    target = n_checked + 2 * WORDS;
    @(posedge i_aclk);
    rand_ready = 1'b1;
    @(negedge i_aclk);
    i_fetch_en = 1'b1;
    wait (n_checked >= target);
    repeat (4) @(posedge i_aclk);
    if (n_bresp == n_writes) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      report_problem($sformatf("%0d writes gave %0d responses", n_writes, n_bresp));
    end
  end

endmodule

// ==== source/fetch_top.sv ====
// Fetch front end top: instruction SRAM, fetch FSM, queue and decode register
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module fetch_top import ifu_pkg::*; (
  input  logic                   i_aclk,
  input  logic                   i_rst_n,
  input  logic                   i_fetch_en,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [`IFU_ADDR_W-1:0] i_awaddr,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  input  logic [`IFU_DATA_W-1:0] i_wdata,
  input  logic [`IFU_STRB_W-1:0] i_wstrb,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  output axi_resp_e              o_bresp,
  output logic                   o_dec_valid,
  input  logic                   i_dec_ready,
  output logic [`IFU_ADDR_W-1:0] o_dec_pc,
  output logic [31:0]            o_dec_inst,
  output inst_class_e            o_dec_class
);

  axil_rd_if     rd_bus ();
  inst_stream_if fetch_stream ();
  inst_stream_if queue_stream ();

  inst_sram u_inst_sram (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .rd        (rd_bus.slave)
  );

  inst_fetch u_inst_fetch (
    .i_aclk     (i_aclk),
    .i_rst_n    (i_rst_n),
    .i_fetch_en (i_fetch_en),
    .rd         (rd_bus.master),
    .o_stream   (fetch_stream.src)
  );

  inst_queue u_inst_queue (
    .i_aclk   (i_aclk),
    .i_rst_n  (i_rst_n),
    .i_stream (fetch_stream.dst),
    .o_stream (queue_stream.src)
  );

  inst_decode u_inst_decode (
    .i_aclk      (i_aclk),
    .i_rst_n     (i_rst_n),
    .i_stream    (queue_stream.dst),
    .o_dec_valid (o_dec_valid),
    .i_dec_ready (i_dec_ready),
    .o_dec_pc    (o_dec_pc),
    .o_dec_inst  (o_dec_inst),
    .o_dec_class (o_dec_class)
  );

endmodule

// ==== source/inst_decode.sv ====
// Decode output register that classifies each instruction by its major opcode
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module inst_decode import ifu_pkg::*; (
  input  logic                   i_aclk,
  input  logic                   i_rst_n,
  inst_stream_if.dst             i_stream,
  output logic                   o_dec_valid,
  input  logic                   i_dec_ready,
  output logic [`IFU_ADDR_W-1:0] o_dec_pc,
  output logic [31:0]            o_dec_inst,
  output inst_class_e            o_dec_class
);

  // RV64 major opcodes, bits 6 to 0
  typedef enum logic [6:0] {
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011,
    OPC_LOAD      = 7'b0000011,
    OPC_STORE     = 7'b0100011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_OP_32     = 7'b0111011,
    OPC_SYSTEM    = 7'b1110011,
    OPC_MISC_MEM  = 7'b0001111
  } opcode_e;

  opcode_e     opcode;
  inst_class_e cls;
  logic        load;

  assign opcode = opcode_e'(i_stream.inst[6:0]);

  always_comb begin
    case (opcode)
      OPC_LUI:       cls = IC_LUI;
      OPC_AUIPC:     cls = IC_AUIPC;
      OPC_JAL:       cls = IC_JAL;
      OPC_JALR:      cls = IC_JALR;
      OPC_BRANCH:    cls = IC_BRANCH;
      OPC_LOAD:      cls = IC_LOAD;
      OPC_STORE:     cls = IC_STORE;
      OPC_OP_IMM:    cls = IC_OP_IMM;
      OPC_OP:        cls = IC_OP;
      OPC_OP_IMM_32: cls = IC_OP_IMM_32;
      OPC_OP_32:     cls = IC_OP_32;
      OPC_SYSTEM:    cls = IC_SYSTEM;
      OPC_MISC_MEM:  cls = IC_MISC_MEM;
      default:       cls = IC_ILLEGAL;
    endcase
  end

  // Take a new entry when empty or when the current one leaves
  assign i_stream.ready = !o_dec_valid || i_dec_ready;
  assign load           = i_stream.valid && i_stream.ready;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_dec_valid <= 1'b0;
    end else if (i_stream.ready) begin
      o_dec_valid <= i_stream.valid;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (load) begin
      o_dec_pc    <= i_stream.pc;
      o_dec_inst  <= i_stream.inst;
      o_dec_class <= cls;
    end
  end

endmodule

// ==== source/inst_queue.sv ====
// Synchronous FIFO carrying PC and instruction pairs from fetch to decode
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module inst_queue import ifu_pkg::*; (
  input  logic         i_aclk,
  input  logic         i_rst_n,
  inst_stream_if.dst   i_stream,
  inst_stream_if.src   o_stream
);

  localparam int PTR_W = $clog2(`IFU_QUEUE_DEPTH);

  logic [`IFU_ADDR_W-1:0] pc_mem   [`IFU_QUEUE_DEPTH];
  logic [31:0]            inst_mem [`IFU_QUEUE_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [PTR_W:0]         count;
  logic                   push;
  logic                   pop;

  assign push = i_stream.valid && i_stream.ready;
  assign pop  = o_stream.valid && o_stream.ready;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally since the depth is a power of two
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge i_aclk) begin
    if (push) begin
      pc_mem[wr_ptr]   <= i_stream.pc;
      inst_mem[wr_ptr] <= i_stream.inst;
    end
  end

  assign i_stream.ready = (count != (PTR_W+1)'(`IFU_QUEUE_DEPTH));
  assign o_stream.valid = (count != '0);
  assign o_stream.pc    = pc_mem[rd_ptr];
  assign o_stream.inst  = inst_mem[rd_ptr];

endmodule

// ==== source/inst_fetch.sv ====
// Sequential instruction fetch FSM with one outstanding AXI-lite read
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module inst_fetch import ifu_pkg::*; (
  input  logic         i_aclk,
  input  logic         i_rst_n,
  input  logic         i_fetch_en,
  axil_rd_if.master    rd,
  inst_stream_if.src   o_stream
);

  localparam int HALF_W = `IFU_DATA_W / 2;

  fetch_state_e           state;
  logic [`IFU_ADDR_W-1:0] pc;
  logic                   slot_valid;
  logic [`IFU_ADDR_W-1:0] slot_pc;
  logic [HALF_W-1:0]      slot_inst;
  logic                   rd_take;
  logic [HALF_W-1:0]      half;

  // Word aligned read address
  assign rd.arvalid = (state == FS_REQ);
  assign rd.araddr  = {pc[`IFU_ADDR_W-1:3], 3'b000};

  // Hold off read data while the stream slot is occupied
  assign rd.rready = (state == FS_WAIT) && !slot_valid;
  assign rd_take   = rd.rvalid && rd.rready;

  // PC bit 2 picks the upper instruction of the pair
  assign half = pc[2] ? rd.rdata[`IFU_DATA_W-1:HALF_W] : rd.rdata[HALF_W-1:0];

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= FS_IDLE;
      pc         <= `IFU_RESET_PC;
      slot_valid <= 1'b0;
    end else begin
      case (state)
        FS_IDLE: if (i_fetch_en) state <= FS_REQ;
        FS_REQ:  if (rd.arready) state <= FS_WAIT;
        FS_WAIT: begin
          if (rd_take) begin
            pc    <= pc + 'd4;
            state <= i_fetch_en ? FS_REQ : FS_IDLE;
          end
        end
        default: state <= FS_IDLE;
      endcase
      if (rd_take) begin
        slot_valid <= 1'b1;
      end else if (o_stream.ready) begin
        slot_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (rd_take) begin
      slot_pc   <= pc;
      slot_inst <= half;
    end
  end

  assign o_stream.valid = slot_valid;
  assign o_stream.pc    = slot_pc;
  assign o_stream.inst  = slot_inst;

endmodule

// ==== source/inst_sram.sv ====
// Instruction SRAM behind an AXI-lite slave with strobed writes and registered reads
`timescale 1ns/1ns
`include "ifu_cfg.svh"

module inst_sram import ifu_pkg::*; (
  input  logic                   i_aclk,
  input  logic                   i_rst_n,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  logic [`IFU_ADDR_W-1:0] i_awaddr,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  input  logic [`IFU_DATA_W-1:0] i_wdata,
  input  logic [`IFU_STRB_W-1:0] i_wstrb,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  output axi_resp_e              o_bresp,
  axil_rd_if.slave               rd
);

  localparam int OFF_W = $clog2(`IFU_STRB_W);
  localparam int IDX_W = $clog2(`IFU_MEM_WORDS);

  logic [`IFU_DATA_W-1:0] mem [`IFU_MEM_WORDS];
  logic [IDX_W-1:0]       wr_idx;
  logic [IDX_W-1:0]       rd_idx;
  logic                   wr_en;
  logic                   rd_en;
  logic                   arready_q;
  logic                   rvalid_q;
  logic [`IFU_DATA_W-1:0] rdata_q;

  // Upper address bits are dropped so accesses wrap around the array
  assign wr_idx = i_awaddr[OFF_W +: IDX_W];
  assign rd_idx = rd.araddr[OFF_W +: IDX_W];

  // Accept a write once per handshake, only if the response slot frees up
  assign wr_en = i_awvalid && i_wvalid && (!o_bvalid || i_bready) && !o_awready && !o_wready;
  assign rd_en = rd.arvalid && (!rvalid_q || rd.rready) && !arready_q;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      o_awready <= wr_en;
      o_wready  <= wr_en;
      o_bvalid  <= wr_en || (o_bvalid && !i_bready);
      arready_q <= rd_en;
      rvalid_q  <= rd_en || (rvalid_q && !rd.rready);
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_en) begin
      for (int b = 0; b < `IFU_STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[wr_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
    // Read data stays put until the next accepted read
    if (rd_en) begin
      rdata_q <= mem[rd_idx];
    end
  end

  assign o_bresp    = RESP_OKAY;
  assign rd.arready = arready_q;
  assign rd.rvalid  = rvalid_q;
  assign rd.rdata   = rdata_q;
  assign rd.rresp   = RESP_OKAY;

endmodule

// ==== source/ifu_if.sv ====
// Internal bundles: AXI-lite read channel and the PC/instruction stream
`timescale 1ns/1ns
`include "ifu_cfg.svh"

interface axil_rd_if import ifu_pkg::*; ();
  logic                   arvalid;
  logic                   arready;
  logic [`IFU_ADDR_W-1:0] araddr;
  logic                   rvalid;
  logic                   rready;
  logic [`IFU_DATA_W-1:0] rdata;
  axi_resp_e              rresp;

  modport master (output arvalid, araddr, rready, input arready, rvalid, rdata, rresp);
  modport slave  (input arvalid, araddr, rready, output arready, rvalid, rdata, rresp);
endinterface

interface inst_stream_if ();
  logic                   valid;
  logic                   ready;
  logic [`IFU_ADDR_W-1:0] pc;
  logic [31:0]            inst;

  // Transfer when valid and ready are both high
  modport src (output valid, pc, inst, input ready);
  modport dst (input valid, pc, inst, output ready);
endinterface

// ==== source/ifu_pkg.sv ====
// Fetch front end package: FSM state, instruction class and AXI response types
`include "ifu_cfg.svh"

package ifu_pkg;

  typedef enum logic [1:0] {
    FS_IDLE = 2'd0,
    FS_REQ  = 2'd1,
    FS_WAIT = 2'd2
  } fetch_state_e;

  // Decided only by the RV64 major opcode
  typedef enum logic [3:0] {
    IC_LUI,
    IC_AUIPC,
    IC_JAL,
    IC_JALR,
    IC_BRANCH,
    IC_LOAD,
    IC_STORE,
    IC_OP_IMM,
    IC_OP,
    IC_OP_IMM_32,
    IC_OP_32,
    IC_SYSTEM,
    IC_MISC_MEM,
    IC_ILLEGAL
  } inst_class_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// ==== source/ifu_cfg.svh ====
// Fetch front end configuration: bus widths, memory and queue sizes, reset PC
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// AXI-lite bus widths
`define IFU_DATA_W 64
`define IFU_ADDR_W 32
`define IFU_STRB_W (`IFU_DATA_W / 8)

// Instruction SRAM size in 64-bit words, addresses wrap above this
`define IFU_MEM_WORDS 64

// Entries in the fetch to decode queue, must be a power of two
`define IFU_QUEUE_DEPTH 4

// First fetch address after reset
`define IFU_RESET_PC 32'h0000_0000

`endif
